/* link_tests.txt */
# one phase per line: mode (0 stream, 1 consumer stall, 2 random), words,
# consumer stall cycles, first word in hex; later words come from the lcg
0 8 0 a5a5
0 40 0 0001
1 24 200 beef
0 12 0 ffff
1 32 300 0000
2 240 3 1234
2 200 6 8000

/* src.f */
link_pkg.sv
link_async_fifo.sv
link_two_fifo.sv
link_source_sync_downstream.sv
link_source_sync_upstream.sv
link_top.sv
tb_link.sv

/* Bender.yml */
package:
  name: link

sources:
  - link_pkg.sv
  - link_async_fifo.sv
  - link_two_fifo.sv
  - link_source_sync_downstream.sv
  - link_source_sync_upstream.sv
  - link_top.sv
  - target: simulation
    files:
      - tb_link.sv

/* tb_link.sv */
// self-checking testbench for link_top, reads one phase per line from link_tests.txt
// sender runs on io_clk_i, consumer on core_clk_i, a queue holds the expected words
`timescale 1ns/1ps

module tb_link;

  localparam int max_phases = 32;

  logic                    io_clk_i;
  logic                    core_clk_i;
  logic                    rst_n_i;
  link_pkg::channel_data_t tx_data_i;
  logic                    tx_valid_i;
  logic                    tx_ready_o;
  link_pkg::channel_data_t rx_data_o;
  logic                    rx_valid_o;
  logic                    rx_yumi_i;

  // phase table: mode, word count, consumer stall, first word
  int ph_mode  [max_phases];
  int ph_words [max_phases];
  int ph_stall [max_phases];
  int ph_first [max_phases];
  int num_phases;
  int p;
  int limit;
  int core_cycles;
  int errors;
  int checks;
  int phase_acc;
  // separate random streams for sender and consumer
  logic [31:0] tx_lcg_state;
  logic [31:0] rx_lcg_state;
  link_pkg::channel_data_t model_q [$];

  link_top UUT
    (.io_clk_i  (io_clk_i)
    ,.core_clk_i(core_clk_i)
    ,.rst_n_i   (rst_n_i)
    ,.tx_data_i (tx_data_i)
    ,.tx_valid_i(tx_valid_i)
    ,.tx_ready_o(tx_ready_o)
    ,.rx_data_o (rx_data_o)
    ,.rx_valid_o(rx_valid_o)
    ,.rx_yumi_i (rx_yumi_i)
    );

  // ****************************************
  // clocks and helpers
  // ****************************************

  initial
  begin
    core_clk_i = 1'b0;
    forever #10 core_clk_i = ~core_clk_i;
  end

  // io clock, unrelated period so edges drift against the core clock
  initial
  begin
    io_clk_i = 1'b0;
    forever #13 io_clk_i = ~io_clk_i;
  end

  // one step of the linear congruential generator
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // columns: mode, words, stall, first word; comment lines fail the scan and are skipped
  task automatic read_tests();
    int fd;
    int r;
    int m, w, s, d;
    string line;
    num_phases = 0;
    fd = $fopen("link_tests.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the tests file link_tests.txt");
    end
    else
    begin
      while (!$feof(fd) && num_phases < max_phases)
      begin
        r = $fscanf(fd, "%d %d %d %h\n", m, w, s, d);
        if (r == 4)
        begin
          ph_mode[num_phases]  = m;
          ph_words[num_phases] = w;
          ph_stall[num_phases] = s;
          ph_first[num_phases] = d;
          num_phases++;
          limit = limit + 50 * (w + s);
        end
        else
          r = $fgets(line, fd);
      end
      $fclose(fd);
    end
  endtask

  // ****************************************
  // sender and consumer
  // ****************************************

  // mode 2 offers words at random, other modes offer every cycle
  task automatic send_words(input int mode, input int n, input int first);
    int sent;
    logic want;
    link_pkg::channel_data_t word;
    sent = 0;
    word = link_pkg::channel_data_t'(first);
    while (sent < n)
    begin
      @(negedge io_clk_i);
      if (mode == 2)
      begin
        tx_lcg_state = lcg_step(tx_lcg_state);
        want = tx_lcg_state[16];
      end
      else
        want = 1'b1;
      tx_valid_i = want;
      tx_data_i  = word;
      // credits only move on the rising edge, so ready is settled here
      if (want && tx_ready_o)
      begin
        model_q.push_back(word);
        phase_acc++;
        sent++;
        tx_lcg_state = lcg_step(tx_lcg_state);
        word = link_pkg::channel_data_t'(tx_lcg_state >> 16);
      end
    end
    @(negedge io_clk_i);
    tx_valid_i = 1'b0;
  endtask

  task automatic receive_words(input int mode, input int n, input int stall);
    int got;
    int wait_cycles;
    got = 0;
    wait_cycles = (mode == 1) ? stall : 0;
    while (got < n)
    begin
      @(negedge core_clk_i);
      rx_yumi_i = 1'b0;
      if (wait_cycles > 0)
      begin
        wait_cycles--;
        // end of a long stall, every credit spent and no more
        if (mode == 1 && wait_cycles == 0)
        begin
          check_value("words accepted in stall", link_pkg::fifo_depth, phase_acc);
          check_value("tx_ready_o", 0, tx_ready_o);
        end
      end
      else if (rx_valid_o)
      begin
        rx_yumi_i = 1'b1;
        got++;
        if (model_q.size() == 0)
        begin
          errors++;
          $display("a word came out at %0t that was never sent", $time);
        end
        else
          check_value("rx_data_o", model_q.pop_front(), rx_data_o);
        if (mode == 2)
        begin
          rx_lcg_state = lcg_step(rx_lcg_state);
          wait_cycles = (rx_lcg_state >> 16) % (stall + 1);
        end
      end
    end
    @(negedge core_clk_i);
    rx_yumi_i = 1'b0;
  endtask

  // ****************************************
  // main sequence and watchdog
  // ****************************************

  initial
  begin
    rst_n_i      = 1'b0;
    tx_valid_i   = 1'b0;
    tx_data_i    = '0;
    rx_yumi_i    = 1'b0;
    errors       = 0;
    checks       = 0;
    limit        = 0;
    core_cycles  = 0;
    phase_acc    = 0;
    tx_lcg_state = 32'd46;
    // consumer stream starts from the inverted seed
    rx_lcg_state = ~32'd46;
    read_tests();
    repeat (2) @(posedge core_clk_i);
    @(negedge core_clk_i);
    rst_n_i = 1'b1;
    repeat (4) @(negedge core_clk_i);
    check_value("tx_ready_o", 1, tx_ready_o);
    check_value("rx_valid_o", 0, rx_valid_o);
    for (p = 0; p < num_phases; p++)
    begin
      phase_acc = 0;
      fork
        send_words(ph_mode[p], ph_words[p], ph_first[p]);
        receive_words(ph_mode[p], ph_words[p], ph_stall[p]);
      join
      // link must be quiet once the phase is through, no duplicates
      repeat (8) @(negedge core_clk_i);
      check_value("rx_valid_o", 0, rx_valid_o);
    end
    check_value("words left in model", 0, model_q.size());
    $display("phases %0d, checks %0d, errors %0d", num_phases, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    wait (limit > 0);
    while (core_cycles < limit)
    begin
      @(posedge core_clk_i);
      core_cycles++;
    end
    $display("timeout, the link stopped moving words after %0d core cycles", core_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* link_top.sv */
// loops the send side into the receive side so the whole link runs
// from plain ports: sender on io_clk_i, consumer on core_clk_i
`timescale 1ns/1ps

module link_top
  (input                           io_clk_i
  ,input                           core_clk_i
  ,input                           rst_n_i

  // sender, valid/ready on io_clk_i
  ,input  link_pkg::channel_data_t tx_data_i
  ,input                           tx_valid_i
  ,output                          tx_ready_o

  // consumer, valid/yumi on core_clk_i
  ,output link_pkg::channel_data_t rx_data_o
  ,output                          rx_valid_o
  ,input                           rx_yumi_i
  );

  // link wires between the two sides
  link_pkg::channel_data_t io_data;
  logic                    io_valid;
  // token level, crosses back into io_clk_i inside upstream
  logic                    core_token;

  link_source_sync_upstream upstream
    (.io_clk_i  (io_clk_i)
    ,.rst_n_i   (rst_n_i)
    ,.tx_data_i (tx_data_i)
    ,.tx_valid_i(tx_valid_i)
    ,.tx_ready_o(tx_ready_o)
    ,.io_data_o (io_data)
    ,.io_valid_o(io_valid)
    ,.io_token_i(core_token)
    );

  link_source_sync_downstream downstream
    (.io_clk_i      (io_clk_i)
    ,.core_clk_i    (core_clk_i)
    ,.rst_n_i       (rst_n_i)
    ,.io_data_i     (io_data)
    ,.io_valid_i    (io_valid)
    ,.core_token_r_o(core_token)
    ,.core_data_o   (rx_data_o)
    ,.core_valid_o  (rx_valid_o)
    ,.core_yumi_i   (rx_yumi_i)
    );

endmodule

/* link_source_sync_upstream.sv */
// send side of the link: takes sender words on a valid/ready handshake,
// launches them from flops and spends one credit each
// credits come back in batches on every edge of the token line
`timescale 1ns/1ps

module link_source_sync_upstream
  (input                           io_clk_i
  ,input                           rst_n_i

  // sender side
  ,input  link_pkg::channel_data_t tx_data_i
  ,input                           tx_valid_i
  ,output                          tx_ready_o

  // link side
  ,output link_pkg::channel_data_t io_data_o
  ,output                          io_valid_o
  // token level from the receiver, core clock domain
  ,input                           io_token_i
  );

  link_pkg::credit_cnt_t   credit_r, credit_n;
  link_pkg::channel_data_t io_data_r;
  logic                    io_valid_r;
  logic                    tx_accept;

  // ****************************************
  // launch
  // ****************************************

  // any credit left means the receive fifo has a free slot
  assign tx_ready_o = (credit_r != '0);
  assign tx_accept  = tx_valid_i & tx_ready_o;

  // data only loads on an accepted word
  always_ff @(posedge io_clk_i)
  begin
    if (tx_accept)
      io_data_r <= tx_data_i;
  end

  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      io_valid_r <= 1'b0;
    else
      io_valid_r <= tx_accept;
  end

  assign io_data_o  = io_data_r;
  assign io_valid_o = io_valid_r;

  // ****************************************
  // token sync and credits
  // ****************************************

  // two-flop synchronizer, then one more flop to compare against
  logic [1:0] token_sync_r;
  logic       token_prev_r;
  logic       token_edge;

  // rising or falling edge, each one is a batch of credits
  assign token_edge = token_sync_r[1] ^ token_prev_r;

  always_comb
  begin
    credit_n = credit_r;
    if (token_edge)
      credit_n = credit_n + link_pkg::credit_cnt_t'(link_pkg::credits_per_token);
    // both in one cycle nets credits_per_token minus one
    if (tx_accept)
      credit_n = credit_n - link_pkg::credit_cnt_t'(1);
  end

  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      token_sync_r <= 2'b00;
      token_prev_r <= 1'b0;
      // start with the whole receive fifo available
      credit_r     <= link_pkg::credit_cnt_t'(link_pkg::fifo_depth);
    end
    else
    begin
      token_sync_r <= {token_sync_r[0], io_token_i};
      token_prev_r <= token_sync_r[1];
      credit_r     <= credit_n;
    end
  end

endmodule

/* link_source_sync_downstream.sv */
// receive side of the link: io words enter an async fifo that is also the
// receive buffer, cross to core_clk_i and leave through a two-entry buffer
// each dequeue from the async fifo counts toward a returned token edge
`timescale 1ns/1ps

module link_source_sync_downstream
  (input                           io_clk_i
  ,input                           core_clk_i
  ,input                           rst_n_i

  // from the sender, io_clk_i domain
  ,input  link_pkg::channel_data_t io_data_i
  ,input                           io_valid_i
  // token level back to the sender, straight from a flop
  ,output                          core_token_r_o

  // to the consumer, core_clk_i domain
  ,output link_pkg::channel_data_t core_data_o
  ,output                          core_valid_o
  ,input                           core_yumi_i
  );

  // ****************************************
  // clock crossing and receive buffer
  // ****************************************

  link_pkg::channel_data_t core_fifo_data;
  logic                    core_fifo_valid;
  logic                    core_fifo_ready;
  logic                    core_fifo_deq;

  // sender holds at most fifo_depth credits, so every valid word has room
  // full never asserts and is left open
  link_async_fifo async_fifo
    (.w_clk_i  (io_clk_i)
    ,.r_clk_i  (core_clk_i)
    ,.rst_n_i  (rst_n_i)

    ,.w_enq_i  (io_valid_i)
    ,.w_data_i (io_data_i)
    ,.w_full_o ()

    ,.r_deq_i  (core_fifo_deq)
    ,.r_data_o (core_fifo_data)
    ,.r_valid_o(core_fifo_valid)
    );

  // move a word across whenever the async fifo has one and the buffer has room
  assign core_fifo_deq = core_fifo_valid & core_fifo_ready;

  // short buffer cuts the long async fifo read path off from the consumer
  link_two_fifo two_fifo
    (.core_clk_i(core_clk_i)
    ,.rst_n_i   (rst_n_i)

    ,.v_i       (core_fifo_valid)
    ,.data_i    (core_fifo_data)
    ,.ready_o   (core_fifo_ready)

    ,.v_o       (core_valid_o)
    ,.data_o    (core_data_o)
    ,.yumi_i    (core_yumi_i)
    );

  // ****************************************
  // token return
  // ****************************************

  // dequeue counter, wraps freely
  link_pkg::token_cnt_t token_cnt_r;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      token_cnt_r <= '0;
    else if (core_fifo_deq)
      token_cnt_r <= token_cnt_r + link_pkg::token_cnt_t'(1);
  end

  // top bit flips once per credits_per_token dequeues
  // taken from the counter flop so the line never glitches
  assign core_token_r_o = token_cnt_r[link_pkg::lg_token_decimation];

endmodule

/* link_two_fifo.sv */
// two-entry buffer, ready/valid on the input and valid/yumi on the output
// ready_o comes only from flops, so paths into it end here
`timescale 1ns/1ps

module link_two_fifo
  (input                           core_clk_i
  ,input                           rst_n_i

  ,input                           v_i
  ,input  link_pkg::channel_data_t data_i
  ,output                          ready_o

  ,output                          v_o
  ,output link_pkg::channel_data_t data_o
  ,input                           yumi_i
  );

  // two payload entries
  link_pkg::channel_data_t mem_r [2];

  // head is the read slot, tail the write slot
  logic head_r, tail_r;
  logic full_r, empty_r;
  logic enq, deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[head_r];

  assign enq = v_i & ready_o;
  // consumer only yumis a valid word
  assign deq = yumi_i;

  always_ff @(posedge core_clk_i)
  begin
    if (enq)
      mem_r[tail_r] <= data_i;
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_r  <= 1'b0;
      tail_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end
    else
    begin
      if (enq)
        tail_r <= ~tail_r;
      if (deq)
        head_r <= ~head_r;
      // empty stays if nothing comes in, or becomes so when the last word leaves
      empty_r <= (empty_r & ~enq) | (~full_r & deq & ~enq);
      // full stays until a word leaves, or fills when the second word comes in
      full_r  <= (full_r & ~deq) | (~empty_r & enq & ~deq);
    end
  end

endmodule

/* link_async_fifo.sv */
// dual-clock FIFO with gray-coded pointers crossing through two-flop synchronizers
// full is flagged on the write side, valid on the read side, both conservative
`timescale 1ns/1ps

module link_async_fifo
  (input                         w_clk_i
  ,input                         r_clk_i
  ,input                         rst_n_i

  // write side, w_clk_i domain
  ,input                         w_enq_i
  ,input  link_pkg::channel_data_t w_data_i
  ,output                        w_full_o

  // read side, r_clk_i domain
  ,input                         r_deq_i
  ,output link_pkg::channel_data_t r_data_o
  ,output                        r_valid_o
  );

  // binary to gray, one bit changes per increment
  function automatic link_pkg::fifo_ptr_t bin2gray(input link_pkg::fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // payload storage
  link_pkg::channel_data_t mem_r [link_pkg::fifo_depth];

  // write side pointers
  link_pkg::fifo_ptr_t  w_ptr_bin_r, w_ptr_bin_n;
  link_pkg::fifo_ptr_t  w_ptr_gray_r;
  // read gray pointer brought into the write domain
  link_pkg::fifo_ptr_t  w_rgray_s1_r, w_rgray_s2_r;
  link_pkg::fifo_ptr_t  w_full_cmp;
  link_pkg::fifo_addr_t w_addr;
  logic                 w_push;

  // read side pointers
  link_pkg::fifo_ptr_t  r_ptr_bin_r, r_ptr_bin_n;
  link_pkg::fifo_ptr_t  r_ptr_gray_r;
  // write gray pointer brought into the read domain
  link_pkg::fifo_ptr_t  r_wgray_s1_r, r_wgray_s2_r;
  link_pkg::fifo_addr_t r_addr;
  logic                 r_pop;

  // ****************************************
  // write side
  // ****************************************

  assign w_addr      = w_ptr_bin_r[link_pkg::lg_fifo_depth-1:0];
  assign w_ptr_bin_n = w_ptr_bin_r + link_pkg::fifo_ptr_t'(1);

  // full when the write pointer is one lap ahead of the read pointer
  // in gray code that means the top two bits differ and the rest match
  assign w_full_cmp = w_rgray_s2_r ^ {2'b11, {(link_pkg::lg_fifo_depth-1){1'b0}}};
  assign w_full_o   = (w_ptr_gray_r == w_full_cmp);

  // never write over unread data
  assign w_push = w_enq_i & ~w_full_o;

  always_ff @(posedge w_clk_i)
  begin
    if (w_push)
      mem_r[w_addr] <= w_data_i;
  end

  always_ff @(posedge w_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      w_ptr_bin_r  <= '0;
      w_ptr_gray_r <= '0;
      w_rgray_s1_r <= '0;
      w_rgray_s2_r <= '0;
    end
    else
    begin
      // two-flop synchronizer on the read pointer
      w_rgray_s1_r <= r_ptr_gray_r;
      w_rgray_s2_r <= w_rgray_s1_r;
      if (w_push)
      begin
        w_ptr_bin_r  <= w_ptr_bin_n;
        // gray pointer straight from a flop so it crosses glitch free
        w_ptr_gray_r <= bin2gray(w_ptr_bin_n);
      end
    end
  end

  // ****************************************
  // read side
  // ****************************************

  assign r_addr      = r_ptr_bin_r[link_pkg::lg_fifo_depth-1:0];
  assign r_ptr_bin_n = r_ptr_bin_r + link_pkg::fifo_ptr_t'(1);

  // not empty once the synchronized write pointer has moved past us
  assign r_valid_o = (r_ptr_gray_r != r_wgray_s2_r);
  assign r_pop     = r_deq_i & r_valid_o;

  // head word read straight from the array
  assign r_data_o = mem_r[r_addr];

  always_ff @(posedge r_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      r_ptr_bin_r  <= '0;
      r_ptr_gray_r <= '0;
      r_wgray_s1_r <= '0;
      r_wgray_s2_r <= '0;
    end
    else
    begin
      // two-flop synchronizer on the write pointer
      r_wgray_s1_r <= w_ptr_gray_r;
      r_wgray_s2_r <= r_wgray_s1_r;
      if (r_pop)
      begin
        r_ptr_bin_r  <= r_ptr_bin_n;
        r_ptr_gray_r <= bin2gray(r_ptr_bin_n);
      end
    end
  end

endmodule

/* link_pkg.sv */
// shared sizes and types for the credit-controlled source-synchronous link
// every block refers to these by scoped name, link_pkg::name

package link_pkg;

  // ****************************************
  // channel
  // ****************************************

  // width of one link word
  localparam int unsigned channel_width = 16;

  typedef logic [channel_width-1:0] channel_data_t;

  // ****************************************
  // receive buffer and credits
  // ****************************************

  // async fifo holds 2^lg_fifo_depth words
  // the sender starts with the same number of credits
  localparam int unsigned lg_fifo_depth = 4;
  localparam int unsigned fifo_depth    = 1 << lg_fifo_depth;

  // fifo pointer with one extra wrap bit, binary or gray coded
  typedef logic [lg_fifo_depth:0] fifo_ptr_t;

  // memory address, pointer without the wrap bit
  typedef logic [lg_fifo_depth-1:0] fifo_addr_t;

  // 0 to fifo_depth credits inclusive, so one bit more than the address
  typedef logic [lg_fifo_depth:0] credit_cnt_t;

  // ****************************************
  // token return
  // ****************************************

  // one token edge stands for 2^lg_token_decimation credits
  localparam int unsigned lg_token_decimation = 2;
  localparam int unsigned credits_per_token   = 1 << lg_token_decimation;

  // dequeue counter on the receive side, top bit is the token level
  typedef logic [lg_token_decimation:0] token_cnt_t;

endpackage
